// ==== source/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

   // bus geometry
   localparam int unsigned ADDR_W = 16;
   localparam int unsigned DATA_W = 32;

   // native data bus request, a write is any request with nonzero wstrb
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [DATA_W/8-1:0] wstrb;
   } bus_req_t;

   // read answer, one cycle after the request
   typedef struct packed {
      logic              rvalid;
      logic [DATA_W-1:0] rdata;
   } bus_resp_t;

   // address map, top two address bits select the slave
   localparam int unsigned N_SLAVES = 3;

   localparam logic [1:0] SEL_MEM   = 2'd0;
   localparam logic [1:0] SEL_TIMER = 2'd1;
   localparam logic [1:0] SEL_BOOT  = 2'd2;
   // select value 3 is left unmapped

   // boot rom size as byte address width
   localparam int unsigned BOOTROM_ADDR_W = 10;

   // cpu reset pulse length in cycles
   localparam int unsigned CPU_RESET_CYCLES = 4;

   // timer registers, word offsets inside the timer region
   localparam int unsigned TIMER_CTRL_OFFS  = 0;
   localparam int unsigned TIMER_COUNT_OFFS = 1;

endpackage

`default_nettype wire

// ==== source/soc_bus_split.sv ====
`default_nettype none

module soc_bus_split
   import soc_pkg::*;
#(
   parameter int unsigned ADDR_W = soc_pkg::ADDR_W
) (
   input  logic                       clk_i,
   input  logic                       rst_i,

   // master side
   input  bus_req_t                   m_req_i,
   output bus_resp_t                  m_resp_o,

   // slave side
   output bus_req_t  [N_SLAVES-1:0]   s_req_o,
   input  bus_resp_t [N_SLAVES-1:0]   s_resp_i
);

   logic [1:0] sel;
   logic       is_write;
   logic       unmapped;

   // select and unmapped flag of the request being answered
   logic [1:0] sel_q;
   logic       unmapped_rd_q;

   assign sel      = m_req_i.addr[ADDR_W-1 -: 2];
   assign is_write = |m_req_i.wstrb;
   assign unmapped = (sel >= 2'(N_SLAVES));

   // same payload to every slave, valid only to the selected one
   always_comb begin
      for (int i = 0; i < N_SLAVES; i++) begin
         s_req_o[i]       = m_req_i;
         s_req_o[i].valid = m_req_i.valid && (sel == 2'(i));
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sel_q         <= SEL_MEM;
         unmapped_rd_q <= 1'b0;
      end else begin
         if (m_req_i.valid) begin
            sel_q <= sel;
         end
         unmapped_rd_q <= m_req_i.valid && !is_write && unmapped;
      end
   end

   // response mux
   // an unmapped read still gets an answer, zero data, so the cpu never stalls
   always_comb begin
      m_resp_o = '0;
      if (unmapped_rd_q) begin
         m_resp_o.rvalid = 1'b1;
         m_resp_o.rdata  = '0;
      end else begin
         for (int i = 0; i < N_SLAVES; i++) begin
            if (sel_q == 2'(i)) begin
               m_resp_o = s_resp_i[i];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/soc_int_mem.sv ====
`default_nettype none

module soc_int_mem
   import soc_pkg::*;
#(
   parameter int unsigned ADDR_W         = soc_pkg::ADDR_W,
   parameter int unsigned SRAM_ADDR_W    = 12,
   parameter int unsigned BOOTROM_ADDR_W = soc_pkg::BOOTROM_ADDR_W
) (
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  bus_req_t                  req_i,
   output bus_resp_t                 resp_o,

   input  logic                      boot_i,

   // external boot rom, data comes back the cycle after the request
   output logic                      rom_r_valid_o,
   output logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [DATA_W-1:0]         rom_r_rdata_i
);

   localparam int unsigned SRAM_WORDS = 2 ** (SRAM_ADDR_W - 2);

   logic [DATA_W-1:0]      sram [SRAM_WORDS];
   logic [SRAM_ADDR_W-3:0] word_addr;
   logic                   is_write;
   logic                   rd_req;
   logic                   in_rom;

   logic                   rd_q;
   logic                   rom_q;
   logic [DATA_W-1:0]      sram_rdata_q;

   assign word_addr = req_i.addr[SRAM_ADDR_W-1:2];
   assign is_write  = |req_i.wstrb;
   assign rd_req    = req_i.valid && !is_write;

   // offset inside the memory region below the rom size
   assign in_rom = (req_i.addr[ADDR_W-3:BOOTROM_ADDR_W] == '0);

   // reads during boot go to the rom
   assign rom_r_valid_o = rd_req && boot_i && in_rom;
   assign rom_r_addr_o  = req_i.addr[BOOTROM_ADDR_W-1:2];

   // sram with byte strobes
   // writes always land here, even under the rom window
   always_ff @(posedge clk_i) begin
      if (req_i.valid) begin
         for (int b = 0; b < DATA_W / 8; b++) begin
            if (req_i.wstrb[b]) begin
               sram[word_addr][8*b +: 8] <= req_i.wdata[8*b +: 8];
            end
         end
         sram_rdata_q <= sram[word_addr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_q  <= 1'b0;
         rom_q <= 1'b0;
      end else begin
         rd_q  <= rd_req;
         rom_q <= rom_r_valid_o;
      end
   end

   // rom data passes straight through in the answer cycle
   assign resp_o.rvalid = rd_q;
   assign resp_o.rdata  = rom_q ? rom_r_rdata_i : sram_rdata_q;

endmodule

`default_nettype wire

// ==== source/soc_timer.sv ====
`default_nettype none

module soc_timer
   import soc_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   input  bus_req_t  req_i,
   output bus_resp_t resp_o
);

   logic              is_write;
   logic              ctrl_sel;
   logic              count_sel;

   logic              enable_q;
   logic [31:0]       count_q;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   assign is_write  = |req_i.wstrb;
   assign ctrl_sel  = (req_i.addr[2] == TIMER_CTRL_OFFS[0]);
   assign count_sel = (req_i.addr[2] == TIMER_COUNT_OFFS[0]);

   // control register, bit 0 enables counting
   // count register loads a full word on any strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q <= 1'b0;
         count_q  <= '0;
      end else begin
         if (req_i.valid && is_write && ctrl_sel && req_i.wstrb[0]) begin
            enable_q <= req_i.wdata[0];
         end
         // load wins over increment
         if (req_i.valid && is_write && count_sel) begin
            count_q <= req_i.wdata;
         end else if (enable_q) begin
            count_q <= count_q + 32'd1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= req_i.valid && !is_write;
      end
   end

   // count read gives the value held at the request edge
   always_ff @(posedge clk_i) begin
      if (req_i.valid && !is_write) begin
         rdata_q <= count_sel ? count_q : {{(DATA_W-1){1'b0}}, enable_q};
      end
   end

   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== source/soc_boot_ctrl.sv ====
`default_nettype none

module soc_boot_ctrl
   import soc_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,

   input  bus_req_t  req_i,
   output bus_resp_t resp_o,

   output logic      boot_o,
   output logic      cpu_reset_o
);

   localparam int unsigned CNT_W = $clog2(CPU_RESET_CYCLES + 1);

   logic              wr_req;
   logic              boot_q;
   logic [CNT_W-1:0]  rst_cnt_q;
   logic              rvalid_q;
   logic [DATA_W-1:0] rdata_q;

   assign wr_req = req_i.valid && (|req_i.wstrb);

   // boot flag drops on any write
   // the counter reloads on reset and on that write, then runs down
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         boot_q    <= 1'b1;
         rst_cnt_q <= CNT_W'(CPU_RESET_CYCLES);
         rvalid_q  <= 1'b0;
      end else begin
         rvalid_q <= req_i.valid && !(|req_i.wstrb);
         if (wr_req) begin
            boot_q    <= 1'b0;
            rst_cnt_q <= CNT_W'(CPU_RESET_CYCLES);
         end else if (rst_cnt_q != '0) begin
            rst_cnt_q <= rst_cnt_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_q <= {{(DATA_W-1){1'b0}}, boot_q};
   end

   assign boot_o      = boot_q;
   assign cpu_reset_o = (rst_cnt_q != '0);

   assign resp_o.rvalid = rvalid_q;
   assign resp_o.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== source/soc_top.sv ====
`default_nettype none

module soc_top
   import soc_pkg::*;
#(
   parameter int unsigned ADDR_W         = soc_pkg::ADDR_W,
   parameter int unsigned SRAM_ADDR_W    = 12,
   parameter int unsigned BOOTROM_ADDR_W = soc_pkg::BOOTROM_ADDR_W
) (
   input  logic                      clk_i,
   input  logic                      rst_i,

   // cpu data bus
   input  bus_req_t                  req_i,
   output bus_resp_t                 resp_o,

   // boot rom
   output logic                      rom_r_valid_o,
   output logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o,
   input  logic [DATA_W-1:0]         rom_r_rdata_i,

   output logic                      boot_o,
   output logic                      cpu_reset_o
);

   bus_req_t  [N_SLAVES-1:0] slaves_req;
   bus_resp_t [N_SLAVES-1:0] slaves_resp;

   logic boot;

   soc_bus_split #(
      .ADDR_W (ADDR_W)
   ) dbus_split (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .m_req_i  (req_i),
      .m_resp_o (resp_o),
      .s_req_o  (slaves_req),
      .s_resp_i (slaves_resp)
   );

   soc_int_mem #(
      .ADDR_W         (ADDR_W),
      .SRAM_ADDR_W    (SRAM_ADDR_W),
      .BOOTROM_ADDR_W (BOOTROM_ADDR_W)
   ) int_mem0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_i         (slaves_req[SEL_MEM]),
      .resp_o        (slaves_resp[SEL_MEM]),
      .boot_i        (boot),
      .rom_r_valid_o (rom_r_valid_o),
      .rom_r_addr_o  (rom_r_addr_o),
      .rom_r_rdata_i (rom_r_rdata_i)
   );

   soc_timer timer0 (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .req_i  (slaves_req[SEL_TIMER]),
      .resp_o (slaves_resp[SEL_TIMER])
   );

   soc_boot_ctrl boot_ctrl0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (slaves_req[SEL_BOOT]),
      .resp_o      (slaves_resp[SEL_BOOT]),
      .boot_o      (boot),
      .cpu_reset_o (cpu_reset_o)
   );

   assign boot_o = boot;

endmodule

`default_nettype wire

// ==== bench/soc_tb_model.svh ====
`ifndef SOC_TB_MODEL_SVH
`define SOC_TB_MODEL_SVH

// model state, advanced once per rising edge
logic [DATA_W-1:0] sram_mdl [2 ** (SRAM_ADDR_W - 2)];
logic              boot_mdl;
int unsigned       rst_cnt_mdl;
logic              tmr_en_mdl;
logic [31:0]       tmr_cnt_mdl;

// rom contents, every word address bit shows up in the data
function automatic logic [DATA_W-1:0] rom_word(input logic [BOOTROM_ADDR_W-3:0] waddr);
   logic [7:0] a;
   a = 8'(waddr);
   return {a, ~a, a ^ 8'h5a, a + 8'h3c};
endfunction

function automatic void reset_model();
   boot_mdl    = 1'b1;
   rst_cnt_mdl = CPU_RESET_CYCLES;
   tmr_en_mdl  = 1'b0;
   tmr_cnt_mdl = '0;
endfunction

// memory region below the rom size
function automatic logic in_rom_window(input logic [ADDR_W-1:0] addr);
   return (addr[ADDR_W-1 -: 2] == SEL_MEM) && (addr[ADDR_W-3:BOOTROM_ADDR_W] == '0);
endfunction

function automatic logic rom_read_expected(input bus_req_t req);
   return req.valid && (req.wstrb == '0) && boot_mdl && in_rom_window(req.addr);
endfunction

// what a read returns, from the state held at the request edge
function automatic logic [DATA_W-1:0] predict_read(input logic [ADDR_W-1:0] addr);
   logic [DATA_W-1:0] val;
   case (addr[ADDR_W-1 -: 2])
      SEL_MEM: begin
         if (boot_mdl && in_rom_window(addr)) begin
            val = rom_word(addr[BOOTROM_ADDR_W-1:2]);
         end else begin
            val = sram_mdl[addr[SRAM_ADDR_W-1:2]];
         end
      end
      SEL_TIMER: val = (addr[ADDR_W-3:2] == TIMER_COUNT_OFFS) ? tmr_cnt_mdl : tmr_en_mdl;
      SEL_BOOT:  val = boot_mdl;
      default:   val = '0;
   endcase
   return val;
endfunction

function automatic void advance_model(input bus_req_t req);
   logic       wr;
   logic [1:0] sel;
   logic       tmr_en_old;
   wr         = req.valid && (req.wstrb != '0);
   sel        = req.addr[ADDR_W-1 -: 2];
   tmr_en_old = tmr_en_mdl;
   if (wr && sel == SEL_MEM) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
         if (req.wstrb[b]) begin
            sram_mdl[req.addr[SRAM_ADDR_W-1:2]][8*b +: 8] = req.wdata[8*b +: 8];
         end
      end
   end
   // a load beats the increment
   if (wr && sel == SEL_TIMER && req.addr[ADDR_W-3:2] == TIMER_COUNT_OFFS) begin
      tmr_cnt_mdl = req.wdata;
   end else if (tmr_en_old) begin
      tmr_cnt_mdl = tmr_cnt_mdl + 1;
   end
   if (wr && sel == SEL_TIMER && req.addr[ADDR_W-3:2] == TIMER_CTRL_OFFS && req.wstrb[0]) begin
      tmr_en_mdl = req.wdata[0];
   end
   if (wr && sel == SEL_BOOT) begin
      boot_mdl    = 1'b0;
      rst_cnt_mdl = CPU_RESET_CYCLES;
   end else if (rst_cnt_mdl != 0) begin
      rst_cnt_mdl--;
   end
endfunction

`endif

// ==== bench/soc_tb.sv ====
`default_nettype none

module soc_tb
   import soc_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned SRAM_ADDR_W   = 12;
   localparam int unsigned WIN_WORDS     = 32;
   localparam int unsigned RESP_TIMEOUT  = 16;
   localparam int unsigned PULSE_TIMEOUT = 32;

   localparam logic [ADDR_W-1:0] TIMER_BASE    = {SEL_TIMER, {(ADDR_W-2){1'b0}}};
   localparam logic [ADDR_W-1:0] BOOT_BASE     = {SEL_BOOT, {(ADDR_W-2){1'b0}}};
   localparam logic [ADDR_W-1:0] UNMAPPED_BASE = {2'd3, {(ADDR_W-2){1'b0}}};
   localparam logic [ADDR_W-1:0] COUNT_ADDR    = TIMER_BASE + 4 * TIMER_COUNT_OFFS;
   localparam logic [DATA_W-1:0] ROM_IDLE      = 32'hbad0_0bad;
   localparam bus_req_t          IDLE_REQ      = '0;

   logic                      clk_i;
   logic                      rst_i;
   bus_req_t                  req_i;
   bus_resp_t                 resp_o;
   logic                      rom_r_valid_o;
   logic [BOOTROM_ADDR_W-3:0] rom_r_addr_o;
   logic [DATA_W-1:0]         rom_r_rdata_i;
   logic                      boot_o;
   logic                      cpu_reset_o;

   logic [31:0]               lcg_state;
   int unsigned               cycle_cnt;
   int unsigned               err_cnt;
   int unsigned               req_edge;
   logic                      pend_rd;
   logic [DATA_W-1:0]         pend_data;
   string                     pend_name;
   bus_resp_t                 resp_s;
   logic                      reset_s;
   logic                      rom_seen_q;
   logic [BOOTROM_ADDR_W-3:0] rom_addr_q;

   `include "soc_tb_model.svh"

   soc_top #(
      .ADDR_W         (ADDR_W),
      .SRAM_ADDR_W    (SRAM_ADDR_W),
      .BOOTROM_ADDR_W (BOOTROM_ADDR_W)
   ) dut0 (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .req_i         (req_i),
      .resp_o        (resp_o),
      .rom_r_valid_o (rom_r_valid_o),
      .rom_r_addr_o  (rom_r_addr_o),
      .rom_r_rdata_i (rom_r_rdata_i),
      .boot_o        (boot_o),
      .cpu_reset_o   (cpu_reset_o)
   );

   always #5 clk_i = ~clk_i;

   // external boot rom returns data for the address of the previous cycle
   always @(posedge clk_i) begin
      rom_seen_q <= rom_r_valid_o;
      rom_addr_q <= rom_r_addr_o;
   end

   always @(negedge clk_i) begin
      rom_r_rdata_i <= rom_seen_q ? rom_word(rom_addr_q) : ROM_IDLE;
   end

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // random value below n from the upper lcg bits
   function automatic int unsigned pick(input int unsigned n);
      logic [31:0] r;
      r = next_rand();
      return r[31:16] % n;
   endfunction

   function automatic logic [DATA_W-1:0] rand_word();
      logic [31:0] hi;
      logic [31:0] lo;
      hi = next_rand();
      lo = next_rand();
      return {hi[31:16], lo[31:16]};
   endfunction

   function automatic logic [3:0] rand_strb();
      return 4'(pick(15) + 1);
   endfunction

   function automatic logic [ADDR_W-1:0] word_addr(input int unsigned w);
      return ADDR_W'(w * 4);
   endfunction

   function automatic bus_req_t make_req(input logic [ADDR_W-1:0] addr,
                                         input logic [DATA_W-1:0] wdata,
                                         input logic [3:0] wstrb);
      bus_req_t r;
      r.valid = 1'b1;
      r.addr  = addr;
      r.wdata = wdata;
      r.wstrb = wstrb;
      return r;
   endfunction

   task automatic check_val(input string name, input logic [DATA_W-1:0] expected,
                            input logic [DATA_W-1:0] actual);
      if (actual !== expected) begin
         err_cnt++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "stopped at first error");
      end
   endtask

   task automatic abort_run(input string why);
      err_cnt++;
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "stopped on timeout");
   endtask

   // one bus cycle between two falling edges
   task automatic tick(input bus_req_t req, input string name);
      logic rom_hit;
      req_i = req;
      @(posedge clk_i);
      cycle_cnt++;
      resp_s  = resp_o;
      reset_s = cpu_reset_o;
      // answer to the request of the previous cycle
      check_val({pend_name, " rvalid"}, pend_rd, resp_o.rvalid);
      if (pend_rd) begin
         check_val(pend_name, pend_data, resp_o.rdata);
      end
      check_val({name, " boot flag"}, boot_mdl, boot_o);
      check_val({name, " cpu reset"}, rst_cnt_mdl != 0, cpu_reset_o);
      rom_hit = rom_read_expected(req);
      check_val({name, " rom valid"}, rom_hit, rom_r_valid_o);
      if (rom_hit) begin
         check_val({name, " rom addr"}, req.addr[BOOTROM_ADDR_W-1:2], rom_r_addr_o);
      end
      pend_rd   = req.valid && (req.wstrb == '0);
      pend_data = predict_read(req.addr);
      pend_name = name;
      advance_model(req);
      @(negedge clk_i);
   endtask

   task automatic idle_cycles(input int unsigned n);
      for (int i = 0; i < n; i++) begin
         tick(IDLE_REQ, "idle");
      end
   endtask

   task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [3:0] strb, input string name);
      tick(make_req(addr, data, strb), name);
   endtask

   // read and wait for the rvalid one cycle later
   task automatic read_expect(input logic [ADDR_W-1:0] addr, input string name,
                              output logic [DATA_W-1:0] data);
      int unsigned waited;
      logic        seen;
      tick(make_req(addr, '0, '0), name);
      req_edge = cycle_cnt;
      waited   = 0;
      seen     = 1'b0;
      while (!seen && waited < RESP_TIMEOUT) begin
         tick(IDLE_REQ, "wait response");
         waited++;
         seen = resp_s.rvalid;
      end
      if (!seen) begin
         abort_run($sformatf("no read response for %s", name));
      end
      data = resp_s.rdata;
   endtask

   task automatic measure_reset_pulse(input string name);
      int unsigned high_cycles;
      int unsigned waited;
      high_cycles = 0;
      waited      = 0;
      reset_s     = 1'b1;
      while (reset_s && waited < PULSE_TIMEOUT) begin
         tick(IDLE_REQ, "reset pulse");
         waited++;
         if (reset_s) begin
            high_cycles++;
         end
      end
      if (reset_s) begin
         abort_run("cpu reset stayed high");
      end
      check_val(name, CPU_RESET_CYCLES, high_cycles);
   endtask

   // a request every cycle into the sram window
   task automatic run_back_to_back(input int unsigned n);
      bus_req_t req;
      for (int i = 0; i < n; i++) begin
         if (pick(2) == 0) begin
            req = make_req(word_addr(pick(WIN_WORDS)), '0, '0);
         end else begin
            req = make_req(word_addr(pick(WIN_WORDS)), rand_word(), rand_strb());
         end
         tick(req, $sformatf("back to back %0d", i));
      end
      tick(IDLE_REQ, "drain");
   endtask

   initial begin
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] first;
      logic [DATA_W-1:0] second;
      int unsigned       edge_a;
      int unsigned       en_edge;
      clk_i         = 1'b0;
      rst_i         = 1'b1;
      req_i         = IDLE_REQ;
      rom_r_rdata_i = ROM_IDLE;
      rom_seen_q    = 1'b0;
      lcg_state     = 32'd74;
      cycle_cnt     = 0;
      err_cnt       = 0;
      pend_rd       = 1'b0;
      pend_name     = "reset";
      repeat (8) begin
         @(posedge clk_i);
      end
      @(negedge clk_i);
      rst_i = 1'b0;
      reset_model();

      measure_reset_pulse("cpu reset pulse after reset");
      check_val("boot flag after reset", 1, boot_o);
      read_expect(BOOT_BASE, "boot register after reset", d);
      check_val("boot register value", 1, d);

      // firmware written under the rom while booting
      for (int w = 0; w < WIN_WORDS; w++) begin
         write_word(word_addr(w), rand_word(), 4'hf, "sram fill");
      end
      for (int i = 0; i < 64; i++) begin
         write_word(word_addr(pick(WIN_WORDS)), rand_word(), rand_strb(), "sram strobe write");
      end
      for (int w = 0; w < WIN_WORDS; w++) begin
         read_expect(word_addr(w), $sformatf("rom read %0d", w), d);
      end

      write_word(BOOT_BASE, rand_word(), 4'hf, "boot clear");
      measure_reset_pulse("cpu reset pulse after boot clear");
      check_val("boot flag after clear", 0, boot_o);
      read_expect(BOOT_BASE, "boot register after clear", d);
      check_val("boot register cleared", 0, d);
      for (int w = 0; w < WIN_WORDS; w++) begin
         read_expect(word_addr(w), $sformatf("sram read %0d", w), d);
      end

      run_back_to_back(200);

      // timer load, run and hold
      d = rand_word();
      write_word(COUNT_ADDR, d, 4'hf, "timer load");
      write_word(TIMER_BASE, 32'd1, 4'h1, "timer enable");
      en_edge = cycle_cnt;
      idle_cycles(pick(10) + 2);
      read_expect(COUNT_ADDR, "timer count a", first);
      edge_a = req_edge;
      check_val("timer count since enable", d + (edge_a - en_edge - 1), first);
      idle_cycles(pick(20) + 1);
      read_expect(COUNT_ADDR, "timer count b", second);
      check_val("timer count step", req_edge - edge_a, second - first);
      write_word(TIMER_BASE, 32'd0, 4'h1, "timer disable");
      read_expect(TIMER_BASE, "timer ctrl", d);
      check_val("timer ctrl disabled", 0, d);
      read_expect(COUNT_ADDR, "timer hold a", first);
      idle_cycles(pick(20) + 1);
      read_expect(COUNT_ADDR, "timer hold b", second);
      check_val("timer count held", first, second);

      for (int i = 0; i < 8; i++) begin
         write_word(UNMAPPED_BASE + word_addr(pick(4096)), rand_word(), 4'hf, "unmapped write");
         read_expect(UNMAPPED_BASE + word_addr(pick(4096)), "unmapped read", d);
         check_val("unmapped data", 0, d);
      end

      if (err_cnt == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+bench
source/soc_pkg.sv
source/soc_bus_split.sv
source/soc_int_mem.sv
source/soc_timer.sv
source/soc_boot_ctrl.sv
source/soc_top.sv
bench/soc_tb.sv

// ==== Bender.yml ====
package:
  name: soc_fabric

sources:
  - source/soc_pkg.sv
  - source/soc_bus_split.sv
  - source/soc_int_mem.sv
  - source/soc_timer.sv
  - source/soc_boot_ctrl.sv
  - source/soc_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/soc_tb.sv
